// ==== flist.f ====
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_victim_ptr.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_top.sv
test/tb_clkgen.sv
test/tb_dcache.sv

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req_i,
    input  logic     hit_i,
    input  logic     victim_dirty_i,
    input  tag_t     victim_tag_i,
    input  line_t    victim_line_i,
    input  logic     mem_finish_i,
    output set_t     index_o,
    output logic     load_hit_o,
    output logic     store_hit_o,
    output logic     refill_o,
    output tag_t     fill_tag_o,
    output logic     request_finish_o,
    output logic     miss_o,
    output mem_req_t mem_req_o
);

    cache_state_e state_q;
    cache_state_e state_d;
    logic         req_valid;
    logic         capture;
    tag_t         miss_tag_q;
    set_t         miss_set_q;
    tag_t         wb_tag_q;
    line_t        wb_line_q;

    assign req_valid = cpu_req_i.read | cpu_req_i.write;

    // arrays look at the live request only while idle
    assign index_o = (state_q == READY) ? cpu_req_i.addr[SET_LSB +: SET_BITS] : miss_set_q;

    assign miss_o           = req_valid && !(hit_i && state_q == READY);
    assign request_finish_o = (state_q == RESPOND);
    assign fill_tag_o       = miss_tag_q;

    assign mem_req_o.write     = (state_q == WRITE_BACK);
    assign mem_req_o.read      = (state_q == REFILL);
    assign mem_req_o.line_addr = mem_req_o.write ? {wb_tag_q, miss_set_q}
                                                 : {miss_tag_q, miss_set_q};
    assign mem_req_o.wline     = wb_line_q;

    always_comb
    begin
        state_d     = state_q;
        load_hit_o  = 1'b0;
        store_hit_o = 1'b0;
        refill_o    = 1'b0;
        capture     = 1'b0;
        case (state_q)
            READY:
            begin
                if (req_valid && hit_i)
                begin
                    load_hit_o  = cpu_req_i.read;
                    store_hit_o = cpu_req_i.write;
                    state_d     = RESPOND;
                end
                else if (req_valid)
                begin
                    // clean victims skip straight to the refill
                    capture = 1'b1;
                    state_d = victim_dirty_i ? WRITE_BACK : REFILL;
                end
            end
            WRITE_BACK:
            begin
                if (mem_finish_i)
                begin
                    state_d = REFILL;
                end
            end
            REFILL:
            begin
                if (mem_finish_i)
                begin
                    refill_o = 1'b1;
                    state_d  = READY;
                end
            end
            default:
            begin
                state_d = READY;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= READY;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // miss address and write-back payload
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            miss_tag_q <= cpu_req_i.addr[TAG_LSB +: TAG_BITS];
            miss_set_q <= cpu_req_i.addr[SET_LSB +: SET_BITS];
            wb_tag_q   <= victim_tag_i;
            wb_line_q  <= victim_line_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_data_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_data_array
    import dcache_pkg::*;
#(
    parameter int WAYS = WAYS_DEFAULT
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  set_t                    set_i,
    input  logic [$clog2(WAYS)-1:0] way_i,
    input  logic [$clog2(WAYS)-1:0] victim_way_i,
    input  cpu_req_t                cpu_req_i,
    input  logic                    load_hit_i,
    input  logic                    store_hit_i,
    input  logic                    refill_i,
    input  line_t                   fill_line_i,
    output logic [31:0]             read_data_o,
    output line_t                   victim_line_o
);

    line_t       data_q [SETS][WAYS];
    word_idx_t   word_idx;
    logic [1:0]  byte_off;
    logic [1:0]  lane;
    logic [31:0] cur_word;
    logic [31:0] merged;

    assign word_idx      = cpu_req_i.addr[BYTE_BITS +: WORD_BITS];
    assign byte_off      = cpu_req_i.addr[BYTE_BITS-1:0];
    assign cur_word      = data_q[set_i][way_i][word_idx];
    assign victim_line_o = data_q[set_i][victim_way_i];

    // offset 0 is the most significant byte
    assign lane = 2'd3 - byte_off;

    always_comb
    begin
        merged = cur_word;
        case (cpu_req_i.store_op)
            STORE_BYTE:
            begin
                merged[{lane, 3'b000} +: 8] = cpu_req_i.wdata[7:0];
            end
            STORE_HALF:
            begin
                if (byte_off[1])
                begin
                    merged[15:0] = cpu_req_i.wdata[15:0];
                end
                else
                begin
                    merged[31:16] = cpu_req_i.wdata[15:0];
                end
            end
            default:
            begin
                merged = cpu_req_i.wdata;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (refill_i)
        begin
            data_q[set_i][victim_way_i] <= fill_line_i;
        end
        else if (store_hit_i)
        begin
            data_q[set_i][way_i][word_idx] <= merged;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            read_data_o <= '0;
        end
        else if (load_hit_i)
        begin
            read_data_o <= cur_word;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // address split into tag | set | word | byte
    localparam int BYTE_BITS    = 2;
    localparam int WORD_BITS    = 3;
    localparam int SET_BITS     = 3;
    localparam int TAG_BITS     = 10;
    localparam int SET_LSB      = BYTE_BITS + WORD_BITS;
    localparam int TAG_LSB      = SET_LSB + SET_BITS;

    localparam int WAYS_DEFAULT = 4;
    localparam int LINE_WORDS   = 1 << WORD_BITS;
    localparam int SETS         = 1 << SET_BITS;

    typedef logic [TAG_BITS-1:0]          tag_t;
    typedef logic [SET_BITS-1:0]          set_t;
    typedef logic [WORD_BITS-1:0]         word_idx_t;
    typedef logic [TAG_BITS+SET_BITS-1:0] line_addr_t;

    // word 0 sits in the top 32 bits
    typedef logic [0:LINE_WORDS-1][31:0] line_t;

    // store size uses the same codes as the cpu funct3
    typedef enum logic [2:0] {
        STORE_BYTE = 3'b000,
        STORE_HALF = 3'b001,
        STORE_WORD = 3'b010
    } store_op_e;

    typedef enum logic [1:0] {
        READY,
        WRITE_BACK,
        REFILL,
        RESPOND
    } cache_state_e;

    typedef struct packed {
        logic        read;
        logic        write;
        store_op_e   store_op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_t line_addr;
        line_t      wline;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== rtl/dcache_tag_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array
    import dcache_pkg::*;
#(
    parameter int WAYS = WAYS_DEFAULT
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  set_t                    set_i,
    input  tag_t                    tag_i,
    input  logic [$clog2(WAYS)-1:0] victim_way_i,
    input  logic                    store_hit_i,
    input  logic                    refill_i,
    input  tag_t                    fill_tag_i,
    output logic                    hit_o,
    output logic [$clog2(WAYS)-1:0] hit_way_o,
    output logic                    victim_dirty_o,
    output tag_t                    victim_tag_o
);

    localparam int WAY_W = $clog2(WAYS);

    tag_t            tag_q   [SETS][WAYS];
    logic [WAYS-1:0] valid_q [SETS];
    logic [WAYS-1:0] dirty_q [SETS];
    logic [WAYS-1:0] hit_vec;

    // all ways of the set compared at once
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++)
        begin
            hit_vec[w] = valid_q[set_i][w] && (tag_q[set_i][w] == tag_i);
            if (hit_vec[w])
            begin
                hit_way_o = WAY_W'(w);
            end
        end
    end

    assign hit_o          = |hit_vec;
    assign victim_dirty_o = valid_q[set_i][victim_way_i] & dirty_q[set_i][victim_way_i];
    assign victim_tag_o   = tag_q[set_i][victim_way_i];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else if (refill_i)
        begin
            // fresh line from memory is clean
            valid_q[set_i][victim_way_i] <= 1'b1;
            dirty_q[set_i][victim_way_i] <= 1'b0;
        end
        else if (store_hit_i)
        begin
            dirty_q[set_i][hit_way_o] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill_i)
        begin
            tag_q[set_i][victim_way_i] <= fill_tag_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int WAYS = WAYS_DEFAULT
)
(
    input  logic        clk,
    input  logic        rst,
    input  cpu_req_t    cpu_req_i,
    output logic        request_finish_o,
    output logic [31:0] read_data_o,
    output logic        miss_o,
    output mem_req_t    mem_req_o,
    input  logic        mem_finish_i,
    input  line_t       mem_rdata_i
);

    set_t                    index;
    logic                    hit;
    logic [$clog2(WAYS)-1:0] hit_way;
    logic [$clog2(WAYS)-1:0] victim_way;
    logic                    victim_dirty;
    tag_t                    victim_tag;
    line_t                   victim_line;
    logic                    load_hit;
    logic                    store_hit;
    logic                    refill;
    tag_t                    fill_tag;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .cpu_req_i        (cpu_req_i),
        .hit_i            (hit),
        .victim_dirty_i   (victim_dirty),
        .victim_tag_i     (victim_tag),
        .victim_line_i    (victim_line),
        .mem_finish_i     (mem_finish_i),
        .index_o          (index),
        .load_hit_o       (load_hit),
        .store_hit_o      (store_hit),
        .refill_o         (refill),
        .fill_tag_o       (fill_tag),
        .request_finish_o (request_finish_o),
        .miss_o           (miss_o),
        .mem_req_o        (mem_req_o)
    );

    // pointer moves on each refill of its set
    dcache_victim_ptr #(.WAYS(WAYS)) u_victim_ptr (
        .clk       (clk),
        .rst       (rst),
        .set_i     (index),
        .advance_i (refill),
        .way_o     (victim_way)
    );

    dcache_tag_array #(.WAYS(WAYS)) u_tag_array (
        .clk            (clk),
        .rst            (rst),
        .set_i          (index),
        .tag_i          (cpu_req_i.addr[TAG_LSB +: TAG_BITS]),
        .victim_way_i   (victim_way),
        .store_hit_i    (store_hit),
        .refill_i       (refill),
        .fill_tag_i     (fill_tag),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_array #(.WAYS(WAYS)) u_data_array (
        .clk           (clk),
        .rst           (rst),
        .set_i         (index),
        .way_i         (hit_way),
        .victim_way_i  (victim_way),
        .cpu_req_i     (cpu_req_i),
        .load_hit_i    (load_hit),
        .store_hit_i   (store_hit),
        .refill_i      (refill),
        .fill_line_i   (mem_rdata_i),
        .read_data_o   (read_data_o),
        .victim_line_o (victim_line)
    );

endmodule

`default_nettype wire

// ==== rtl/dcache_victim_ptr.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_victim_ptr
    import dcache_pkg::*;
#(
    parameter int WAYS = WAYS_DEFAULT
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  set_t                    set_i,
    input  logic                    advance_i,
    output logic [$clog2(WAYS)-1:0] way_o
);

    localparam int WAY_W = $clog2(WAYS);

    logic [WAY_W-1:0] ptr_q [SETS];

    assign way_o = ptr_q[set_i];

    // ways fill in order, so round robin gives fifo replacement
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                ptr_q[s] <= '0;
            end
        end
        else if (advance_i)
        begin
            if (ptr_q[set_i] == WAY_W'(WAYS - 1))
            begin
                ptr_q[set_i] <= '0;
            end
            else
            begin
                ptr_q[set_i] <= ptr_q[set_i] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the data cache testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_dcache \
    --Mdir obj_dir -o tb_dcache > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
exit 1

// ==== test/tb_clkgen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen
(
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period
    initial
    begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held over the first two rising edges
    initial
    begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/tb_dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
;

    localparam int N_DIRECTED = 22;
    localparam int N_RANDOM   = 200;
    localparam int TIMEOUT    = (N_DIRECTED + N_RANDOM) * 40;

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    logic        request_finish_o;
    logic [31:0] read_data_o;
    logic        miss_o;
    mem_req_t    mem_req_o;
    logic        mem_finish_i;
    line_t       mem_rdata_i;

    // memory backing store and the word image the cpu should see
    line_t       mem_lines [0:8191];
    logic [31:0] ref_mem [0:65535];
    logic [31:0] exp_q [$];
    int          seed = 93;
    int          errors = 0;
    int          checks = 0;
    int          wb_count = 0;
    line_addr_t  last_wb_addr;

    tb_clkgen u_clkgen (
        .clk_o (clk),
        .rst_o (rst)
    );

    dcache_top #(.WAYS(WAYS_DEFAULT)) UUT (
        .clk              (clk),
        .rst              (rst),
        .cpu_req_i        (cpu_req),
        .request_finish_o (request_finish_o),
        .read_data_o      (read_data_o),
        .miss_o           (miss_o),
        .mem_req_o        (mem_req_o),
        .mem_finish_i     (mem_finish_i),
        .mem_rdata_i      (mem_rdata_i)
    );

    // initial memory word holds A5 in the top byte and the byte address below
    function automatic logic [31:0] fill_word(input logic [17:0] byte_addr);
        return {8'hA5, 6'b000000, byte_addr};
    endfunction

    function automatic logic [31:0] make_addr(input tag_t tag, input set_t set_idx,
                                              input word_idx_t word, input logic [1:0] off);
        return {14'b0, tag, set_idx, word, off};
    endfunction

    // byte offset 0 is the most significant byte of the word
    function automatic logic [31:0] ref_apply_store(input logic [31:0] old_word,
                                                    input logic [31:0] wdata,
                                                    input store_op_e op,
                                                    input logic [1:0] off);
        logic [4:0]  shift;
        logic [31:0] mask;
        shift = 5'd24 - {off, 3'b000};
        mask  = 32'h0000_00FF << shift;
        case (op)
            STORE_BYTE:
                return (old_word & ~mask) | ({24'b0, wdata[7:0]} << shift);
            STORE_HALF:
                return off[1] ? {old_word[31:16], wdata[15:0]} : {wdata[15:0], old_word[15:0]};
            STORE_WORD:
                return wdata;
            default:
                return old_word;
        endcase
    endfunction

    // issues one cpu request and holds it until the finish pulse
    task automatic run_request(input logic is_write, input store_op_e op,
                               input logic [31:0] addr, input logic [31:0] wdata,
                               output int cycles, output logic saw_miss);
        cpu_req_t    req;
        logic [15:0] widx;
        req          = '0;
        req.read     = ~is_write;
        req.write    = is_write;
        req.store_op = op;
        req.addr     = addr;
        req.wdata    = wdata;
        widx         = addr[17:2];
        @(posedge clk);
        cpu_req <= req;
        if (is_write)
            ref_mem[widx] = ref_apply_store(ref_mem[widx], wdata, op, addr[1:0]);
        else
            exp_q.push_back(ref_mem[widx]);
        cycles   = 0;
        saw_miss = 1'b0;
        do
        begin
            @(posedge clk);
            cycles++;
            if (cycles == 1)
                saw_miss = miss_o;
        end
        while (!request_finish_o);
        cpu_req <= '0;
    endtask

    task automatic load_word(input logic [31:0] addr);
        int   cycles;
        logic saw_miss;
        run_request(1'b0, STORE_WORD, addr, 32'h0, cycles, saw_miss);
    endtask

    task automatic store_data(input store_op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata);
        int   cycles;
        logic saw_miss;
        run_request(1'b1, op, addr, wdata, cycles, saw_miss);
    endtask

    // memory model that answers after 1 to 4 cycles
    initial
    begin
        int busy;
        int wait_cnt;
        busy         = 0;
        wait_cnt     = 0;
        mem_finish_i = 1'b0;
        mem_rdata_i  = '0;
        for (int l = 0; l < 8192; l++)
        begin
            for (int w = 0; w < LINE_WORDS; w++)
                mem_lines[l[12:0]][w[2:0]] = fill_word({l[12:0], w[2:0], 2'b00});
        end
        forever
        begin
            @(posedge clk);
            if (rst)
            begin
                mem_finish_i <= 1'b0;
                busy = 0;
            end
            else if (mem_finish_i)
                mem_finish_i <= 1'b0;
            else if (mem_req_o.read || mem_req_o.write)
            begin
                if (busy == 0)
                begin
                    busy     = 1;
                    wait_cnt = 1 + int'($unsigned($random(seed)) % 4);
                end
                wait_cnt--;
                if (wait_cnt == 0)
                begin
                    busy = 0;
                    if (mem_req_o.write)
                    begin
                        mem_lines[mem_req_o.line_addr] = mem_req_o.wline;
                        last_wb_addr = mem_req_o.line_addr;
                        wb_count++;
                    end
                    else
                        mem_rdata_i <= mem_lines[mem_req_o.line_addr];
                    mem_finish_i <= 1'b1;
                end
            end
        end
    end

    // compares load data and written-back lines with the reference image
    always @(posedge clk)
    begin
        logic [31:0] exp_word;
        if (!rst && request_finish_o && cpu_req.read)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("a load finished at %0t ns with no expected value queued", $time);
            end
            else
            begin
                exp_word = exp_q.pop_front();
                checks++;
                assert (read_data_o == exp_word)
                else
                begin
                    errors++;
                    $display("CHECK FAILED at %0t ns: read_data_o got %h, expected %h",
                             $time, read_data_o, exp_word);
                end
            end
        end
        if (!rst && mem_finish_i && mem_req_o.write)
        begin
            for (int w = 0; w < LINE_WORDS; w++)
            begin
                checks++;
                assert (mem_req_o.wline[w[2:0]] == ref_mem[{mem_req_o.line_addr, w[2:0]}])
                else
                begin
                    errors++;
                    $display("CHECK FAILED at %0t ns: mem_req_o.wline[%0d] got %h, expected %h",
                             $time, w, mem_req_o.wline[w[2:0]],
                             ref_mem[{mem_req_o.line_addr, w[2:0]}]);
                end
            end
        end
    end

    initial
    begin
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout: the cache did not complete the test sequence in %0d cycles", TIMEOUT);
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        int          cycles;
        logic        saw_miss;
        int          wb_start;
        int          pick;
        tag_t        fifo_tags [5];
        tag_t        rtag;
        set_t        rset;
        word_idx_t   rword;
        logic [31:0] rdata;
        logic [31:0] base;
        cpu_req = '0;
        for (int i = 0; i < 65536; i++)
            ref_mem[i[15:0]] = fill_word({i[15:0], 2'b00});
        do
            @(posedge clk);
        while (rst);

        // cold load misses on its first cycle
        run_request(1'b0, STORE_WORD, make_addr(10'h001, 3'd0, 3'd3, 2'd0), 32'h0,
                    cycles, saw_miss);
        checks++;
        assert (saw_miss == 1'b1)
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: miss_o got %b, expected 1", $time, saw_miss);
        end

        // store then load in the same line and then a plain hit
        store_data(STORE_WORD, make_addr(10'h001, 3'd0, 3'd5, 2'd0), 32'hDEAD_BEEF);
        load_word(make_addr(10'h001, 3'd0, 3'd5, 2'd0));
        run_request(1'b0, STORE_WORD, make_addr(10'h001, 3'd0, 3'd6, 2'd0), 32'h0,
                    cycles, saw_miss);
        checks++;
        assert (cycles - 1 == 1)
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: request_finish_o latency got %0d, expected 1",
                     $time, cycles - 1);
        end
        checks++;
        assert (saw_miss == 1'b0)
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: miss_o got %b, expected 0", $time, saw_miss);
        end

        // byte lanes and both halves
        base = make_addr(10'h001, 3'd0, 3'd2, 2'd0);
        for (int off = 0; off < 4; off++)
        begin
            store_data(STORE_BYTE, base | off, 32'h1234_5610 + off);
            load_word(base);
        end
        store_data(STORE_HALF, base, 32'hCAFE_9A9B);
        load_word(base);
        store_data(STORE_HALF, base | 2, 32'hCAFE_7C7D);
        load_word(base);

        // five tags in set 5 so the fifth evicts the first
        wb_start = wb_count;
        for (int k = 0; k < 5; k++)
        begin
            fifo_tags[k] = tag_t'(256 + k);
            if (k == 4)
            begin
                checks++;
                assert (wb_count == wb_start)
                else
                begin
                    errors++;
                    $display("a cold fill of set 5 wrote a line back to memory");
                end
            end
            store_data(STORE_WORD, make_addr(fifo_tags[k], 3'd5, 3'd0, 2'd0), 32'h5500_0000 + k);
        end
        checks++;
        assert (wb_count == wb_start + 1)
        else
        begin
            errors++;
            $display("the fifth tag in set 5 caused %0d line writes instead of one",
                     wb_count - wb_start);
        end
        checks++;
        assert (last_wb_addr == {fifo_tags[0], 3'd5})
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: mem_req_o.line_addr got %h, expected %h",
                     $time, last_wb_addr, {fifo_tags[0], 3'd5});
        end
        load_word(make_addr(fifo_tags[0], 3'd5, 3'd0, 2'd0));

        // random loads and stores over sets 1 to 3
        for (int n = 0; n < N_RANDOM; n++)
        begin
            pick  = $unsigned($random(seed)) % 6;
            rtag  = tag_t'(32 + pick);
            pick  = $unsigned($random(seed)) % 3;
            rset  = set_t'(1 + pick);
            rword = word_idx_t'($unsigned($random(seed)));
            rdata = $random(seed);
            pick  = $unsigned($random(seed)) % 4;
            case (pick)
                0:
                    load_word(make_addr(rtag, rset, rword, 2'd0));
                1:
                    store_data(STORE_BYTE, make_addr(rtag, rset, rword, rdata[9:8]), rdata);
                2:
                    store_data(STORE_HALF, make_addr(rtag, rset, rword, {rdata[9], 1'b0}), rdata);
                default:
                    store_data(STORE_WORD, make_addr(rtag, rset, rword, 2'd0), rdata);
            endcase
        end

        @(posedge clk);
        $display("checks: %0d, errors: %0d, memory writes: %0d", checks, errors, wb_count);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
